//--- logic/hShrink.sv
// Horizontal shrink pattern generator
// Load a shrink value, then each step drops the current even/odd keep pair
`timescale 1ns/1ps

module hShrink import neoPkg::*; (
	input  logic                   CK,
	input  logic                   rstN,
	input  logic [SHRINK_BITS-1:0] shrink,
	input  logic                   shrinkLoad,
	input  logic                   shrinkStep,
	output logic                   keepA,
	output logic                   keepB
);

	// Bit 0 of the keep pattern is the next even pixel
	// The chip splits this over two 8-bit chains, one per pixel phase
	logic [ROW_PIXELS-1:0] pattern;

	always_ff @(posedge CK) begin
		if (!rstN) begin
			pattern <= '0;
		end else if (shrinkLoad) begin
			pattern <= SHRINK_MASK[shrink];
		end else if (shrinkStep) begin
			// Two pixels per clock
			pattern <= {2'b00, pattern[ROW_PIXELS-1:2]};
		end
	end

	// Even pixel of the pair
	assign keepA = pattern[0];

	// Odd pixel of the pair
	assign keepB = pattern[1];

endmodule

//--- logic/lineBuffer.sv
// One-line pixel store, two writes per clock from the serializer
// Scan port reads an entry with one cycle latency and clears it behind the read
`timescale 1ns/1ps

module lineBuffer import neoPkg::*; (
	input  logic                    CK,
	input  logic                    rstN,
	input  logic                    wrEnA,
	input  logic [X_BITS-1:0]       wrXA,
	input  logic                    wrEnB,
	input  logic [X_BITS-1:0]       wrXB,
	input  logic [2*ENTRY_BITS-1:0] wrData,
	input  logic                    rdEn,
	input  logic [X_BITS-1:0]       rdX,
	output logic [ENTRY_BITS-1:0]   rdData,
	output logic                    clearing
);

	logic [ENTRY_BITS-1:0] mem [LINE_WIDTH];
	logic [X_BITS-1:0] clrX;

	// Clear sweep after reset covers one entry per clock
	always_ff @(posedge CK) begin
		if (!rstN) begin
			clearing <= 1'b1;
			clrX     <= '0;
		end else if (clearing) begin
			clrX <= clrX + 1'b1;
			if (clrX == X_BITS'(LINE_WIDTH - 1))
				clearing <= 1'b0;
		end
	end

	// Scan reads of out-of-line positions return empty
	always_ff @(posedge CK) begin
		if (!rstN)
			rdData <= '0;
		else if (rdEn)
			rdData <= (rdX < X_BITS'(LINE_WIDTH)) ? mem[rdX] : '0;
	end

	// Later writes to the same address win
	always_ff @(posedge CK) begin
		if (clearing)
			mem[clrX] <= '0;
		if (rdEn && (rdX < X_BITS'(LINE_WIDTH)))
			mem[rdX] <= '0;
		// Pixels falling off the right edge are dropped
		if (wrEnA && (wrXA < X_BITS'(LINE_WIDTH)))
			mem[wrXA] <= wrData[ENTRY_BITS-1:0];
		if (wrEnB && (wrXB < X_BITS'(LINE_WIDTH)))
			mem[wrXB] <= wrData[2*ENTRY_BITS-1:ENTRY_BITS];
	end

endmodule

//--- logic/neoPkg.sv
// Shared constants, shrink table and serializer state for the sprite line renderer
// Imported by every RTL module and by the testbench
package neoPkg;

	// Line geometry
	localparam int LINE_WIDTH = 320;
	localparam int X_BITS     = 9;

	// Pixel and palette widths
	localparam int PIX_BITS   = 4;
	localparam int PAL_BITS   = 8;
	localparam int ENTRY_BITS = PAL_BITS + PIX_BITS;

	// One tile row holds 16 colour indices with pixel 0 in the lowest nibble
	localparam int ROW_PIXELS = 16;
	localparam int ROW_BITS   = ROW_PIXELS * PIX_BITS;
	localparam int PAIR_STEPS = ROW_PIXELS / 2;
	localparam int STEP_BITS  = $clog2(PAIR_STEPS);

	// Shrink value width
	localparam int SHRINK_BITS = 4;

	// Command queue size and the sender's starting credits
	localparam int QUEUE_DEPTH = 4;
	localparam int QPTR_BITS   = $clog2(QUEUE_DEPTH);

	// Bit i set in a keep pattern means pixel i survives
	// Value s keeps s+1 pixels spread evenly over the row
	localparam logic [ROW_PIXELS-1:0] SHRINK_MASK [16] = '{
		16'h8000, 16'h8080, 16'h8420, 16'h8888,
		16'h9248, 16'hA4A4, 16'hAA54, 16'hAAAA,
		16'hD5AA, 16'hDADA, 16'hEDB6, 16'hEEEE,
		16'hFBDE, 16'hFEFE, 16'hFFFE, 16'hFFFF
	};

	// Serializer FSM
	typedef enum logic [1:0] {
		SER_IDLE,
		SER_LOAD,
		SER_SHIFT
	} serState;

endpackage

//--- logic/pixelSerializer.sv
// Tile row serializer, two pixels per clock
// Pops a command, loads the shrink pattern and packs kept pixels into line buffer writes
`timescale 1ns/1ps

module pixelSerializer import neoPkg::*; (
	input  logic                   CK,
	input  logic                   rstN,
	input  logic                   qValid,
	input  logic [ROW_BITS-1:0]    qPixels,
	input  logic [PAL_BITS-1:0]    qPalette,
	input  logic [X_BITS-1:0]      qX,
	input  logic [SHRINK_BITS-1:0] qShrink,
	output logic                   qPop,
	output logic                   shrinkLoad,
	output logic                   shrinkStep,
	output logic [SHRINK_BITS-1:0] shrink,
	input  logic                   keepA,
	input  logic                   keepB,
	output logic                   wrEnA,
	output logic [X_BITS-1:0]      wrXA,
	output logic                   wrEnB,
	output logic [X_BITS-1:0]      wrXB,
	output logic [2*ENTRY_BITS-1:0] wrData,
	output logic                   idle
);

	serState state;
	logic [STEP_BITS-1:0] stepCnt;
	logic lastStep;

	// Current command with its row shifting down one pixel pair per step
	logic [ROW_BITS-1:0]    pixReg;
	logic [PAL_BITS-1:0]    palReg;
	logic [SHRINK_BITS-1:0] shrinkReg;

	// Running X has a spare bit so a row running past 511 never wraps
	logic [X_BITS:0] curX;
	logic [X_BITS:0] xA;
	logic [X_BITS:0] xB;

	logic [PIX_BITS-1:0] pixA;
	logic [PIX_BITS-1:0] pixB;

	assign lastStep = (state == SER_SHIFT) && (stepCnt == STEP_BITS'(PAIR_STEPS - 1));

	// Pop from idle, or on the last pair so commands run back to back
	assign qPop = qValid && ((state == SER_IDLE) || lastStep);

	always_ff @(posedge CK) begin
		if (!rstN) begin
			state   <= SER_IDLE;
			stepCnt <= '0;
		end else begin
			case (state)
				SER_IDLE: begin
					if (qValid)
						state <= SER_LOAD;
				end
				SER_LOAD: begin
					stepCnt <= '0;
					state   <= SER_SHIFT;
				end
				default: begin
					stepCnt <= stepCnt + 1'b1;
					if (lastStep)
						state <= qValid ? SER_LOAD : SER_IDLE;
				end
			endcase
		end
	end

	// Payload is captured at pop and stepped in SER_SHIFT
	always_ff @(posedge CK) begin
		if (state == SER_SHIFT) begin
			pixReg <= pixReg >> (2 * PIX_BITS);
			curX   <= curX + (X_BITS+1)'(keepA) + (X_BITS+1)'(keepB);
		end
		if (qPop) begin
			pixReg    <= qPixels;
			palReg    <= qPalette;
			shrinkReg <= qShrink;
			curX      <= {1'b0, qX};
		end
	end

	// Shrink block control
	assign shrink     = shrinkReg;
	assign shrinkLoad = (state == SER_LOAD);
	assign shrinkStep = (state == SER_SHIFT);

	assign pixA = pixReg[PIX_BITS-1:0];
	assign pixB = pixReg[2*PIX_BITS-1:PIX_BITS];

	// Odd pixel lands right after the even one only if that was kept
	assign xA = curX;
	assign xB = curX + (X_BITS+1)'(keepA);

	// Colour 0 is transparent but still uses its X slot
	assign wrEnA = (state == SER_SHIFT) && keepA && (pixA != '0) && !xA[X_BITS];
	assign wrEnB = (state == SER_SHIFT) && keepB && (pixB != '0) && !xB[X_BITS];
	assign wrXA  = xA[X_BITS-1:0];
	assign wrXB  = xB[X_BITS-1:0];

	// B entry in the high half and A entry in the low half
	assign wrData = {palReg, pixB, palReg, pixA};

	assign idle = (state == SER_IDLE);

endmodule

//--- logic/spriteCmdQueue.sv
// Sprite command FIFO with credit return
// The sender starts with QUEUE_DEPTH credits and gets one back per pop
`timescale 1ns/1ps

module spriteCmdQueue import neoPkg::*; (
	input  logic                   CK,
	input  logic                   rstN,
	input  logic                   cmdValid,
	input  logic [ROW_BITS-1:0]    cmdPixels,
	input  logic [PAL_BITS-1:0]    cmdPalette,
	input  logic [X_BITS-1:0]      cmdX,
	input  logic [SHRINK_BITS-1:0] cmdShrink,
	input  logic                   qPop,
	output logic                   qValid,
	output logic [ROW_BITS-1:0]    qPixels,
	output logic [PAL_BITS-1:0]    qPalette,
	output logic [X_BITS-1:0]      qX,
	output logic [SHRINK_BITS-1:0] qShrink,
	output logic                   cmdCredit
);

	// One storage array per entry field
	logic [ROW_BITS-1:0]    memPixels [QUEUE_DEPTH];
	logic [PAL_BITS-1:0]    memPalette [QUEUE_DEPTH];
	logic [X_BITS-1:0]      memX [QUEUE_DEPTH];
	logic [SHRINK_BITS-1:0] memShrink [QUEUE_DEPTH];

	logic [QPTR_BITS-1:0] wrPtr;
	logic [QPTR_BITS-1:0] rdPtr;
	logic [QPTR_BITS:0]   count;

	// Credits guarantee a free slot, so a push is never refused
	always_ff @(posedge CK) begin
		if (cmdValid) begin
			memPixels[wrPtr]  <= cmdPixels;
			memPalette[wrPtr] <= cmdPalette;
			memX[wrPtr]       <= cmdX;
			memShrink[wrPtr]  <= cmdShrink;
		end
	end

	// Pointers, occupancy and the credit pulse
	always_ff @(posedge CK) begin
		if (!rstN) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			count     <= '0;
			cmdCredit <= 1'b0;
		end else begin
			if (cmdValid)
				wrPtr <= wrPtr + 1'b1;
			if (qPop)
				rdPtr <= rdPtr + 1'b1;
			case ({cmdValid, qPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Credit goes back the cycle after the slot frees
			cmdCredit <= qPop;
		end
	end

	// Head entry is visible one cycle after its push
	assign qValid   = (count != '0);
	assign qPixels  = memPixels[rdPtr];
	assign qPalette = memPalette[rdPtr];
	assign qX       = memX[rdPtr];
	assign qShrink  = memShrink[rdPtr];

endmodule

//--- logic/spriteLineTop.sv
// Sprite line renderer top level
// Commands go in through a credit-controlled queue, the finished line is read back by scan
`timescale 1ns/1ps

module spriteLineTop import neoPkg::*; (
	input  logic                   CK,
	input  logic                   rstN,
	input  logic                   cmdValid,
	input  logic [ROW_BITS-1:0]    cmdPixels,
	input  logic [PAL_BITS-1:0]    cmdPalette,
	input  logic [X_BITS-1:0]      cmdX,
	input  logic [SHRINK_BITS-1:0] cmdShrink,
	input  logic                   rdEn,
	input  logic [X_BITS-1:0]      rdX,
	output logic                   cmdCredit,
	output logic                   busy,
	output logic [ENTRY_BITS-1:0]  rdData
);

	// Queue head to serializer
	logic                   qValid;
	logic                   qPop;
	logic [ROW_BITS-1:0]    qPixels;
	logic [PAL_BITS-1:0]    qPalette;
	logic [X_BITS-1:0]      qX;
	logic [SHRINK_BITS-1:0] qShrink;

	// Serializer and shrink block
	logic                   shrinkLoad;
	logic                   shrinkStep;
	logic [SHRINK_BITS-1:0] shrink;
	logic                   keepA;
	logic                   keepB;
	logic                   serIdle;

	// Line buffer write side
	logic                    wrEnA;
	logic [X_BITS-1:0]       wrXA;
	logic                    wrEnB;
	logic [X_BITS-1:0]       wrXB;
	logic [2*ENTRY_BITS-1:0] wrData;
	logic                    clearing;

	spriteCmdQueue uQueue (
		.CK, .rstN, .cmdValid, .cmdPixels, .cmdPalette, .cmdX, .cmdShrink,
		.qPop, .qValid, .qPixels, .qPalette, .qX, .qShrink, .cmdCredit
	);

	hShrink uShrink (.CK, .rstN, .shrink, .shrinkLoad, .shrinkStep, .keepA, .keepB);

	pixelSerializer uSer (
		.CK, .rstN, .qValid, .qPixels, .qPalette, .qX, .qShrink,
		.qPop, .shrinkLoad, .shrinkStep, .shrink, .keepA, .keepB,
		.wrEnA, .wrXA, .wrEnB, .wrXB, .wrData, .idle(serIdle)
	);

	lineBuffer uLine (
		.CK, .rstN, .wrEnA, .wrXA, .wrEnB, .wrXB, .wrData,
		.rdEn, .rdX, .rdData, .clearing
	);

	// Line is final once the sweep is done and no command is pending or in flight
	assign busy = clearing || qValid || !serIdle;

endmodule

//--- run.sh
#!/bin/sh
# Build the sprite line renderer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
	--top-module spriteLineTb -o spriteLineSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/spriteLineSim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
	exit 0
fi
echo "Pass message not found"
exit 1

//--- test/spriteLineTb.sv
// Testbench for the sprite line renderer
// Random sprite commands from a fixed seed, checked against a line model by scan read-back
`timescale 1ns/1ps

module spriteLineTb import neoPkg::*; ();

	localparam int TIMEOUT     = 2000;
	localparam int RANDOM_CMDS = 40;

	logic                   CK;
	logic                   rstN;
	logic                   cmdValid;
	logic [ROW_BITS-1:0]    cmdPixels;
	logic [PAL_BITS-1:0]    cmdPalette;
	logic [X_BITS-1:0]      cmdX;
	logic [SHRINK_BITS-1:0] cmdShrink;
	logic                   rdEn;
	logic [X_BITS-1:0]      rdX;
	logic                   cmdCredit;
	logic                   busy;
	logic [ENTRY_BITS-1:0]  rdData;

	// Expected line contents
	logic [ENTRY_BITS-1:0] model [LINE_WIDTH];

	integer seed;
	int errors;
	int cmdsSent;
	int creditsBack = 0;
	int creditErrors = 0;

	tbClock clkGen (.CK, .rstN);

	spriteLineTop uut (
		.CK, .rstN, .cmdValid, .cmdPixels, .cmdPalette, .cmdX, .cmdShrink,
		.rdEn, .rdX, .cmdCredit, .busy, .rdData
	);

	// Count returned credits and flag a sender holding more than the queue depth
	always @(negedge CK) begin
		if (rstN === 1'b1 && cmdCredit === 1'b1) begin
			creditsBack++;
			if (creditsBack > cmdsSent) begin
				creditErrors++;
				$display("At %0t the sender holds more credits than the queue has slots", $time);
			end
		end
	end

	function automatic int creditsHeld();
		return QUEUE_DEPTH - cmdsSent + creditsBack;
	endfunction

	task automatic initInputs();
		cmdValid   <= 1'b0;
		cmdPixels  <= '0;
		cmdPalette <= '0;
		cmdX       <= '0;
		cmdShrink  <= '0;
		rdEn       <= 1'b0;
		rdX        <= '0;
	endtask

	// Walk pixels 0 to 15 and give every kept pixel the next X
	task automatic modelCmd(input logic [ROW_BITS-1:0] pix, input logic [PAL_BITS-1:0] pal,
			input int x, input logic [SHRINK_BITS-1:0] s);
		int curX;
		logic [ROW_PIXELS-1:0] mask;
		logic [PIX_BITS-1:0] p;
		curX = x;
		mask = SHRINK_MASK[s];
		for (int i = 0; i < ROW_PIXELS; i++) begin
			if (mask[4'(i)]) begin
				p = PIX_BITS'(pix >> (i * PIX_BITS));
				// Transparent or off the line, X still advances
				if (p != '0 && curX < LINE_WIDTH)
					model[X_BITS'(curX)] = {pal, p};
				curX++;
			end
		end
	endtask

	// Leaves cmdValid high so the next call can follow back to back
	task automatic sendCmd(input logic [ROW_BITS-1:0] pix, input logic [PAL_BITS-1:0] pal,
			input int x, input logic [SHRINK_BITS-1:0] s);
		int n;
		n = 0;
		@(posedge CK);
		while (creditsHeld() == 0 && n < TIMEOUT) begin
			cmdValid <= 1'b0;
			@(posedge CK);
			n++;
		end
		if (creditsHeld() == 0) begin
			errors++;
			cmdValid <= 1'b0;
			$display("Timed out at %0t waiting for a command credit", $time);
		end else begin
			cmdsSent++;
			cmdValid   <= 1'b1;
			cmdPixels  <= pix;
			cmdPalette <= pal;
			cmdX       <= X_BITS'(x);
			cmdShrink  <= s;
			modelCmd(pix, pal, x, s);
		end
	endtask

	// The last command enters the queue at this edge and busy follows
	task automatic endBurst();
		@(posedge CK);
		cmdValid <= 1'b0;
		@(negedge CK);
		if (busy !== 1'b1) begin
			errors++;
			$display("[ERROR] %0t busy after a command expected 1 got %b", $time, busy);
		end
	endtask

	// All credits home, then busy low
	task automatic waitDrained();
		int n;
		n = 0;
		while (creditsHeld() != QUEUE_DEPTH && n < TIMEOUT) begin
			@(posedge CK);
			n++;
		end
		if (creditsHeld() != QUEUE_DEPTH) begin
			errors++;
			$display("Timed out at %0t with %0d of %0d credits back", $time,
				creditsHeld(), QUEUE_DEPTH);
		end
		n = 0;
		while (busy !== 1'b0 && n < TIMEOUT) begin
			@(negedge CK);
			n++;
		end
		if (busy !== 1'b0) begin
			errors++;
			$display("Timed out at %0t waiting for busy to fall", $time);
		end
	endtask

	// One scan read with data sampled mid-cycle after the latency cycle
	task automatic readEntry(input int x, output logic [ENTRY_BITS-1:0] d);
		@(posedge CK);
		rdEn <= 1'b1;
		rdX  <= X_BITS'(x);
		@(posedge CK);
		rdEn <= 1'b0;
		@(negedge CK);
		d = rdData;
	endtask

	// Compare the whole line with the model and count the filled entries
	task automatic checkLine(output int kept);
		logic [ENTRY_BITS-1:0] d;
		kept = 0;
		for (int x = 0; x < LINE_WIDTH; x++) begin
			readEntry(x, d);
			if (d !== model[X_BITS'(x)]) begin
				errors++;
				$display("[ERROR] %0t rdData at x=%0d expected %h got %h", $time, x,
					model[X_BITS'(x)], d);
			end
			if (d != '0)
				kept++;
			// Read leaves the entry empty
			model[X_BITS'(x)] = '0;
		end
	endtask

	initial begin
		int n;
		int kept;
		int x;
		logic [31:0] r;
		logic [ROW_BITS-1:0] pix;
		logic [ENTRY_BITS-1:0] d;
		seed = 32'hc53f6c4d;
		errors = 0;
		cmdsSent = 0;
		n = 0;
		for (int i = 0; i < LINE_WIDTH; i++)
			model[X_BITS'(i)] = '0;
		initInputs();
		while (rstN !== 1'b1 && n < TIMEOUT) begin
			@(negedge CK);
			n++;
		end
		if (rstN !== 1'b1) begin
			errors++;
			$display("Reset was never released");
		end
		// Clear sweep runs right after reset
		if (busy !== 1'b1) begin
			errors++;
			$display("[ERROR] %0t busy during clear sweep expected 1 got %b", $time, busy);
		end
		waitDrained();

		// Line straight after the clear sweep
		checkLine(kept);

		// Unshrunk row gives 16 entries in a row from x=100
		sendCmd(64'h123456789ABCDEF1, 8'h5A, 100, 4'd15);
		endBurst();
		waitDrained();
		checkLine(kept);
		if (kept != 16) begin
			errors++;
			$display("[ERROR] %0t filled entries expected 16 got %0d", $time, kept);
		end
		// Second read of a read position
		readEntry(100, d);
		if (d !== '0) begin
			errors++;
			$display("[ERROR] %0t rdData reread at x=100 expected %h got %h", $time,
				ENTRY_BITS'(0), d);
		end

		// Random burst sent as fast as credits allow
		for (int c = 0; c < RANDOM_CMDS; c++) begin
			r = $random(seed);
			pix = {$random(seed), $random(seed)};
			if (r[15:13] == 3'b000)
				pix = '0;
			case (r[11:10])
				2'b00:   x = 296 + int'(r[4:0]);
				2'b01:   x = int'(r[8:0]);
				default: x = int'(r[8:0]) % LINE_WIDTH;
			endcase
			sendCmd(pix, r[23:16], x, r[27:24]);
		end
		endBurst();
		waitDrained();
		checkLine(kept);

		// Each shrink value on a line of its own
		for (int s = 0; s < 16; s++) begin
			sendCmd(64'hF123456789ABCDEF, 8'(s + 1), s * 16, 4'(s));
			endBurst();
			waitDrained();
			checkLine(kept);
			if (kept != s + 1) begin
				errors++;
				$display("[ERROR] %0t filled entries for shrink %0d expected %0d got %0d",
					$time, s, s + 1, kept);
			end
		end

		errors = errors + creditErrors;
		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- test/tbClock.sv
// Testbench clock and reset source
// 10 ns clock, active-low reset held for the first two rising edges
`timescale 1ns/1ps

module tbClock (
	output logic CK,
	output logic rstN
);

	initial begin
		CK = 1'b0;
		forever #5 CK = ~CK;
	end

	// Reset released on the second rising edge
	initial begin
		rstN = 1'b0;
		repeat (2) @(posedge CK);
		rstN <= 1'b1;
	end

endmodule

//--- vlog.f
logic/neoPkg.sv
logic/spriteCmdQueue.sv
logic/hShrink.sv
logic/pixelSerializer.sv
logic/lineBuffer.sv
logic/spriteLineTop.sv
test/tbClock.sv
test/spriteLineTb.sv
